/* source/id_pkg.sv */
package id_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcode, inst[31:26]
  localparam logic [5:0] op_alu    = 6'h00;
  localparam logic [5:0] op_lu12i  = 6'h05;
  localparam logic [5:0] op_pcaddu = 6'h07;
  localparam logic [5:0] op_mem    = 6'h0a;
  localparam logic [5:0] op_jirl   = 6'h13;
  localparam logic [5:0] op_b      = 6'h14;
  localparam logic [5:0] op_bl     = 6'h15;
  localparam logic [5:0] op_beq    = 6'h16;
  localparam logic [5:0] op_bne    = 6'h17;
  localparam logic [5:0] op_blt    = 6'h18;
  localparam logic [5:0] op_bge    = 6'h19;
  localparam logic [5:0] op_bltu   = 6'h1a;
  localparam logic [5:0] op_bgeu   = 6'h1b;

  // inst[25:22] under op_alu
  localparam logic [3:0] op2_reg   = 4'h0;
  localparam logic [3:0] op2_shift = 4'h1;
  localparam logic [3:0] op2_slti  = 4'h8;
  localparam logic [3:0] op2_sltui = 4'h9;
  localparam logic [3:0] op2_addi  = 4'ha;
  localparam logic [3:0] op2_andi  = 4'hd;
  localparam logic [3:0] op2_ori   = 4'he;
  localparam logic [3:0] op2_xori  = 4'hf;

  // inst[25:22] under op_mem
  localparam logic [3:0] op2_ld_b = 4'h0;
  localparam logic [3:0] op2_ld_h = 4'h1;
  localparam logic [3:0] op2_ld_w = 4'h2;
  localparam logic [3:0] op2_st_b = 4'h4;
  localparam logic [3:0] op2_st_h = 4'h5;
  localparam logic [3:0] op2_st_w = 4'h6;

  // inst[21:20]
  localparam logic [1:0] op3_shift = 2'h0;
  localparam logic [1:0] op3_reg   = 2'h1;

  // inst[19:15]
  localparam logic [4:0] op4_add  = 5'h00;
  localparam logic [4:0] op4_sub  = 5'h02;
  localparam logic [4:0] op4_slt  = 5'h04;
  localparam logic [4:0] op4_sltu = 5'h05;
  localparam logic [4:0] op4_nor  = 5'h08;
  localparam logic [4:0] op4_and  = 5'h09;
  localparam logic [4:0] op4_or   = 5'h0a;
  localparam logic [4:0] op4_xor  = 5'h0b;
  localparam logic [4:0] op4_sll  = 5'h0e;
  localparam logic [4:0] op4_srl  = 5'h0f;
  localparam logic [4:0] op4_sra  = 5'h10;
  localparam logic [4:0] op4_slli = 5'h01;
  localparam logic [4:0] op4_srli = 5'h09;
  localparam logic [4:0] op4_srai = 5'h11;

  // one-hot alu operation, bit positions
  typedef logic [11:0] alu_op_t;
  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  // byte lane mask
  typedef logic [3:0] mem_width_t;
  localparam mem_width_t mem_word = 4'b1111;
  localparam mem_width_t mem_half = 4'b0011;
  localparam mem_width_t mem_byte = 4'b0001;
  localparam mem_width_t mem_none = 4'b0000;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    alu_op_t               alu_op;
    mem_width_t            mem_width;
    logic                  mem_we;
    logic                  res_from_mem;
    logic                  may_jump;
    logic                  use_rj_value;
    logic                  use_less;
    logic                  need_less;
    logic                  use_zero;
    logic                  need_zero;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic                  src2_is_4;
    logic                  gr_we;
    logic [reg_addr_w-1:0] dest;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    // source addresses, compared against the older slot's dest
    logic [reg_addr_w-1:0] rj_addr;
    logic [reg_addr_w-1:0] rkd_addr;
    logic                  use_rj;
    logic                  use_rkd;
    logic                  is_ls;
    logic                  jmp_and_wr;
  } decoded_t;

endpackage

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
  input  logic [id_pkg::xlen-1:0]       inst,
  input  logic [id_pkg::xlen-1:0]       pc,
  output logic [id_pkg::reg_addr_w-1:0] raddr_j,
  output logic [id_pkg::reg_addr_w-1:0] raddr_kd,
  input  logic [id_pkg::xlen-1:0]       rdata_j,
  input  logic [id_pkg::xlen-1:0]       rdata_kd,
  output id_pkg::decoded_t              bundle
);

  logic [5:0] op_31_26;
  logic [3:0] op_25_22;
  logic [1:0] op_21_20;
  logic [4:0] op_19_15;
  logic [id_pkg::reg_addr_w-1:0] rd;
  logic [id_pkg::reg_addr_w-1:0] rj;
  logic [id_pkg::reg_addr_w-1:0] rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic is_alu_grp, is_mem_grp, is_reg3, is_shift_imm;
  logic inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
  logic inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
  logic inst_slti, inst_sltui, inst_addi, inst_andi, inst_ori, inst_xori;
  logic inst_ld_b, inst_ld_h, inst_ld_w, inst_st_b, inst_st_h, inst_st_w;
  logic inst_jirl, inst_b, inst_bl, inst_beq, inst_bne, inst_blt, inst_bge;
  logic inst_bltu, inst_bgeu, inst_lu12i, inst_pcaddu;
  logic is_alu_rr, is_alu_ri, is_load, is_store, is_cmp_branch;
  logic need_ui5, need_si12, need_ui12, need_si16, need_si20, need_si26;
  id_pkg::alu_op_t alu_op;
  id_pkg::mem_width_t mem_width;
  logic [id_pkg::xlen-1:0] imm;

  assign op_31_26 = inst[31:26];
  assign op_25_22 = inst[25:22];
  assign op_21_20 = inst[21:20];
  assign op_19_15 = inst[19:15];
  assign rd  = inst[4:0];
  assign rj  = inst[9:5];
  assign rk  = inst[14:10];
  assign i12 = inst[21:10];
  assign i16 = inst[25:10];
  assign i20 = inst[24:5];
  // offs[15:0] sits above offs[25:16]
  assign i26 = {inst[9:0], inst[25:10]};

  assign is_alu_grp   = op_31_26 == id_pkg::op_alu;
  assign is_mem_grp   = op_31_26 == id_pkg::op_mem;
  assign is_reg3      = is_alu_grp & (op_25_22 == id_pkg::op2_reg) & (op_21_20 == id_pkg::op3_reg);
  assign is_shift_imm = is_alu_grp & (op_25_22 == id_pkg::op2_shift)
                        & (op_21_20 == id_pkg::op3_shift);

  assign inst_add  = is_reg3 & (op_19_15 == id_pkg::op4_add);
  assign inst_sub  = is_reg3 & (op_19_15 == id_pkg::op4_sub);
  assign inst_slt  = is_reg3 & (op_19_15 == id_pkg::op4_slt);
  assign inst_sltu = is_reg3 & (op_19_15 == id_pkg::op4_sltu);
  assign inst_nor  = is_reg3 & (op_19_15 == id_pkg::op4_nor);
  assign inst_and  = is_reg3 & (op_19_15 == id_pkg::op4_and);
  assign inst_or   = is_reg3 & (op_19_15 == id_pkg::op4_or);
  assign inst_xor  = is_reg3 & (op_19_15 == id_pkg::op4_xor);
  assign inst_sll  = is_reg3 & (op_19_15 == id_pkg::op4_sll);
  assign inst_srl  = is_reg3 & (op_19_15 == id_pkg::op4_srl);
  assign inst_sra  = is_reg3 & (op_19_15 == id_pkg::op4_sra);
  assign inst_slli = is_shift_imm & (op_19_15 == id_pkg::op4_slli);
  assign inst_srli = is_shift_imm & (op_19_15 == id_pkg::op4_srli);
  assign inst_srai = is_shift_imm & (op_19_15 == id_pkg::op4_srai);

  assign inst_slti  = is_alu_grp & (op_25_22 == id_pkg::op2_slti);
  assign inst_sltui = is_alu_grp & (op_25_22 == id_pkg::op2_sltui);
  assign inst_addi  = is_alu_grp & (op_25_22 == id_pkg::op2_addi);
  assign inst_andi  = is_alu_grp & (op_25_22 == id_pkg::op2_andi);
  assign inst_ori   = is_alu_grp & (op_25_22 == id_pkg::op2_ori);
  assign inst_xori  = is_alu_grp & (op_25_22 == id_pkg::op2_xori);

  assign inst_ld_b = is_mem_grp & (op_25_22 == id_pkg::op2_ld_b);
  assign inst_ld_h = is_mem_grp & (op_25_22 == id_pkg::op2_ld_h);
  assign inst_ld_w = is_mem_grp & (op_25_22 == id_pkg::op2_ld_w);
  assign inst_st_b = is_mem_grp & (op_25_22 == id_pkg::op2_st_b);
  assign inst_st_h = is_mem_grp & (op_25_22 == id_pkg::op2_st_h);
  assign inst_st_w = is_mem_grp & (op_25_22 == id_pkg::op2_st_w);

  assign inst_jirl   = op_31_26 == id_pkg::op_jirl;
  assign inst_b      = op_31_26 == id_pkg::op_b;
  assign inst_bl     = op_31_26 == id_pkg::op_bl;
  assign inst_beq    = op_31_26 == id_pkg::op_beq;
  assign inst_bne    = op_31_26 == id_pkg::op_bne;
  assign inst_blt    = op_31_26 == id_pkg::op_blt;
  assign inst_bge    = op_31_26 == id_pkg::op_bge;
  assign inst_bltu   = op_31_26 == id_pkg::op_bltu;
  assign inst_bgeu   = op_31_26 == id_pkg::op_bgeu;
  assign inst_lu12i  = (op_31_26 == id_pkg::op_lu12i) & ~inst[25];
  assign inst_pcaddu = (op_31_26 == id_pkg::op_pcaddu) & ~inst[25];

  assign is_alu_rr = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                     | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
  assign is_alu_ri = inst_slti | inst_sltui | inst_addi | inst_andi | inst_ori | inst_xori
                     | inst_slli | inst_srli | inst_srai;
  assign is_load       = inst_ld_b | inst_ld_h | inst_ld_w;
  assign is_store      = inst_st_b | inst_st_h | inst_st_w;
  assign is_cmp_branch = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;

  // branches compare through the alu
  assign alu_op[id_pkg::alu_add]  = inst_add | inst_addi | is_load | is_store | inst_jirl
                                    | inst_bl | inst_pcaddu;
  assign alu_op[id_pkg::alu_sub]  = inst_sub | inst_beq | inst_bne;
  assign alu_op[id_pkg::alu_slt]  = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[id_pkg::alu_sltu] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
  assign alu_op[id_pkg::alu_and]  = inst_and | inst_andi;
  assign alu_op[id_pkg::alu_nor]  = inst_nor;
  assign alu_op[id_pkg::alu_or]   = inst_or | inst_ori;
  assign alu_op[id_pkg::alu_xor]  = inst_xor | inst_xori;
  assign alu_op[id_pkg::alu_sll]  = inst_sll | inst_slli;
  assign alu_op[id_pkg::alu_srl]  = inst_srl | inst_srli;
  assign alu_op[id_pkg::alu_sra]  = inst_sra | inst_srai;
  assign alu_op[id_pkg::alu_lui]  = inst_lu12i;

  assign need_ui5  = inst_slli | inst_srli | inst_srai;
  assign need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
  assign need_ui12 = inst_andi | inst_ori | inst_xori;
  assign need_si16 = inst_jirl | is_cmp_branch;
  assign need_si20 = inst_lu12i | inst_pcaddu;
  assign need_si26 = inst_b | inst_bl;

  assign imm = need_si20 ? {i20, 12'b0} :
               need_ui5  ? {27'b0, rk} :
               need_si26 ? {{6{i26[25]}}, i26} :
               need_si16 ? {{16{i16[15]}}, i16} :
               need_ui12 ? {20'b0, i12} :
               need_si12 ? {{20{i12[11]}}, i12} : '0;

  assign mem_width = (inst_ld_w | inst_st_w) ? id_pkg::mem_word :
                     (inst_ld_h | inst_st_h) ? id_pkg::mem_half :
                     (inst_ld_b | inst_st_b) ? id_pkg::mem_byte : id_pkg::mem_none;

  // stores and two-register branches read rd as second source
  assign raddr_j  = rj;
  assign raddr_kd = (is_store | is_cmp_branch) ? rd : rk;

  always_comb
  begin
    bundle.pc           = pc;
    bundle.alu_op       = alu_op;
    bundle.mem_width    = mem_width;
    bundle.mem_we       = is_store;
    bundle.res_from_mem = is_load;
    bundle.may_jump     = is_cmp_branch | inst_jirl | inst_b | inst_bl;
    bundle.use_rj_value = inst_jirl;
    bundle.use_less     = inst_blt | inst_bge | inst_bltu | inst_bgeu;
    bundle.need_less    = inst_blt | inst_bltu;
    bundle.use_zero     = inst_beq | inst_bne;
    bundle.need_zero    = inst_beq;
    bundle.src1_is_pc   = inst_jirl | inst_bl | inst_pcaddu;
    bundle.src2_is_imm  = is_alu_ri | is_load | is_store | inst_lu12i | inst_pcaddu;
    bundle.src2_is_4    = inst_jirl | inst_bl;
    bundle.gr_we        = is_alu_rr | is_alu_ri | is_load | inst_jirl | inst_bl
                          | inst_lu12i | inst_pcaddu;
    bundle.dest         = inst_bl ? id_pkg::reg_addr_w'(1) : rd;
    bundle.imm          = imm;
    bundle.rj_value     = rdata_j;
    bundle.rkd_value    = rdata_kd;
    bundle.rj_addr      = raddr_j;
    bundle.rkd_addr     = raddr_kd;
    bundle.use_rj       = is_alu_rr | is_alu_ri | is_load | is_store | inst_jirl | is_cmp_branch;
    bundle.use_rkd      = is_alu_rr | is_store | is_cmp_branch;
    bundle.is_ls        = |mem_width;
    bundle.jmp_and_wr   = inst_jirl | inst_bl;
  end

endmodule

/* source/pair_check.sv */
`timescale 1ns/1ps

module pair_check (
  input  id_pkg::decoded_t bundle0,
  input  id_pkg::decoded_t bundle1,
  input  logic             inst0_valid,
  input  logic             inst1_valid,
  input  logic             exe_ready,
  output logic             issue1_ok,
  output logic [1:0]       pop
);

  logic raw_hazard;
  logic both_ls;
  logic link_after_ls;

  // r0 writes never create a dependency
  assign raw_hazard = bundle0.gr_we & (|bundle0.dest)
                      & ((bundle1.use_rj & (bundle0.dest == bundle1.rj_addr))
                      | (bundle1.use_rkd & (bundle0.dest == bundle1.rkd_addr)));

  // single memory port in execute
  assign both_ls = bundle0.is_ls & bundle1.is_ls;

  assign link_after_ls = bundle1.jmp_and_wr & bundle0.is_ls;

  always_comb
  begin
    issue1_ok = inst0_valid & inst1_valid & ~(raw_hazard | both_ls | link_after_ls);
    pop[0]    = inst0_valid & exe_ready;
    pop[1]    = issue1_ok & exe_ready;
  end

endmodule

/* source/issue_reg.sv */
`timescale 1ns/1ps

module issue_reg (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush,
  input  logic             exe_ready,
  input  id_pkg::decoded_t in_bundle0,
  input  id_pkg::decoded_t in_bundle1,
  input  logic             in_valid0,
  input  logic             in_valid1,
  output id_pkg::decoded_t exe_bundle0,
  output id_pkg::decoded_t exe_bundle1,
  output logic             exe_valid0,
  output logic             exe_valid1
);

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush)
    begin
      exe_valid0 <= 1'b0;
      exe_valid1 <= 1'b0;
    end
    else if (exe_ready)
    begin
      exe_valid0 <= in_valid0;
      exe_valid1 <= in_valid1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      exe_bundle0 <= in_bundle0;
      exe_bundle1 <= in_bundle1;
    end
  end

  // slot 1 never issues alone
  a_slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rst_n)
    exe_valid1 |-> exe_valid0);

  a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> (!exe_valid0 && !exe_valid1));

  // held pair stays put until execute takes it
  a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (!exe_ready && !flush) |=> ($stable(exe_valid0) && $stable(exe_valid1)
      && $stable(exe_bundle0) && $stable(exe_bundle1)));

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [id_pkg::xlen-1:0]       inst0,
  input  logic [id_pkg::xlen-1:0]       inst1,
  input  logic [id_pkg::xlen-1:0]       pc0,
  input  logic [id_pkg::xlen-1:0]       pc1,
  input  logic                          inst0_valid,
  input  logic                          inst1_valid,
  output logic [1:0]                    pop,
  output logic [id_pkg::reg_addr_w-1:0] read_addr0,
  output logic [id_pkg::reg_addr_w-1:0] read_addr1,
  output logic [id_pkg::reg_addr_w-1:0] read_addr2,
  output logic [id_pkg::reg_addr_w-1:0] read_addr3,
  input  logic [id_pkg::xlen-1:0]       read_data0,
  input  logic [id_pkg::xlen-1:0]       read_data1,
  input  logic [id_pkg::xlen-1:0]       read_data2,
  input  logic [id_pkg::xlen-1:0]       read_data3,
  output id_pkg::decoded_t              exe_bundle0,
  output id_pkg::decoded_t              exe_bundle1,
  output logic                          exe_valid0,
  output logic                          exe_valid1,
  input  logic                          exe_ready,
  input  logic                          flush
);

  id_pkg::decoded_t bundle0;
  id_pkg::decoded_t bundle1;
  logic issue1_ok;

  // older instruction, read ports 0 and 1
  inst_decoder slot0 (
    .inst     (inst0),
    .pc       (pc0),
    .raddr_j  (read_addr0),
    .raddr_kd (read_addr1),
    .rdata_j  (read_data0),
    .rdata_kd (read_data1),
    .bundle   (bundle0)
  );

  inst_decoder slot1 (
    .inst     (inst1),
    .pc       (pc1),
    .raddr_j  (read_addr2),
    .raddr_kd (read_addr3),
    .rdata_j  (read_data2),
    .rdata_kd (read_data3),
    .bundle   (bundle1)
  );

  pair_check pairing (
    .bundle0     (bundle0),
    .bundle1     (bundle1),
    .inst0_valid (inst0_valid),
    .inst1_valid (inst1_valid),
    .exe_ready   (exe_ready),
    .issue1_ok   (issue1_ok),
    .pop         (pop)
  );

  issue_reg issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .exe_ready   (exe_ready),
    .in_bundle0  (bundle0),
    .in_bundle1  (bundle1),
    .in_valid0   (inst0_valid),
    .in_valid1   (issue1_ok),
    .exe_bundle0 (exe_bundle0),
    .exe_bundle1 (exe_bundle1),
    .exe_valid0  (exe_valid0),
    .exe_valid1  (exe_valid1)
  );

endmodule

/* bench/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;

  localparam int watchdog_cycles = 400;

  typedef struct packed {
    logic [31:0] i0;
    logic [31:0] i1;
    logic [1:0]  valid;
    logic        ready;
    logic        flush;
    logic [1:0]  pop;
    logic [1:0]  ev;
    logic [11:0] alu;
    logic [4:0]  dest;
    logic [31:0] imm;
    logic [31:0] rj;
    logic [31:0] rkd;
    logic [4:0]  dest1;
    logic [31:0] rj1;
    logic [31:0] rkd1;
  } entry_t;

  logic clk = 1'b0;
  logic rst_n;
  logic [id_pkg::xlen-1:0] inst0;
  logic [id_pkg::xlen-1:0] inst1;
  logic [id_pkg::xlen-1:0] pc0;
  logic [id_pkg::xlen-1:0] pc1;
  logic inst0_valid;
  logic inst1_valid;
  logic [1:0] pop;
  logic [id_pkg::reg_addr_w-1:0] read_addr0;
  logic [id_pkg::reg_addr_w-1:0] read_addr1;
  logic [id_pkg::reg_addr_w-1:0] read_addr2;
  logic [id_pkg::reg_addr_w-1:0] read_addr3;
  logic [id_pkg::xlen-1:0] read_data0;
  logic [id_pkg::xlen-1:0] read_data1;
  logic [id_pkg::xlen-1:0] read_data2;
  logic [id_pkg::xlen-1:0] read_data3;
  id_pkg::decoded_t exe_bundle0;
  id_pkg::decoded_t exe_bundle1;
  logic exe_valid0;
  logic exe_valid1;
  logic exe_ready;
  logic flush;

  entry_t table_q[$];
  string name_q[$];
  entry_t e;

  always #5 clk = ~clk;

  id_stage i_id_stage (
    .clk (clk), .rst_n (rst_n), .inst0 (inst0), .inst1 (inst1), .pc0 (pc0), .pc1 (pc1),
    .inst0_valid (inst0_valid), .inst1_valid (inst1_valid), .pop (pop),
    .read_addr0 (read_addr0), .read_addr1 (read_addr1),
    .read_addr2 (read_addr2), .read_addr3 (read_addr3),
    .read_data0 (read_data0), .read_data1 (read_data1),
    .read_data2 (read_data2), .read_data3 (read_data3),
    .exe_bundle0 (exe_bundle0), .exe_bundle1 (exe_bundle1),
    .exe_valid0 (exe_valid0), .exe_valid1 (exe_valid1),
    .exe_ready (exe_ready), .flush (flush)
  );

  // register file model, every byte holds the register number
  function automatic logic [31:0] reg_value(input logic [4:0] addr);
    return {27'b0, addr} * 32'h01010101;
  endfunction

  assign read_data0 = reg_value(read_addr0);
  assign read_data1 = reg_value(read_addr1);
  assign read_data2 = reg_value(read_addr2);
  assign read_data3 = reg_value(read_addr3);

  function automatic logic [31:0] reg3_inst(input logic [4:0] op4, input logic [4:0] rk,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {id_pkg::op_alu, id_pkg::op2_reg, id_pkg::op3_reg, op4, rk, rj, rd};
  endfunction

  function automatic logic [31:0] imm12_inst(input logic [5:0] op, input logic [3:0] op2,
                                             input logic [11:0] i12, input logic [4:0] rj,
                                             input logic [4:0] rd);
    return {op, op2, i12, rj, rd};
  endfunction

  function automatic logic [31:0] shifti_inst(input logic [4:0] op4, input logic [4:0] ui5,
                                              input logic [4:0] rj, input logic [4:0] rd);
    return {id_pkg::op_alu, id_pkg::op2_shift, id_pkg::op3_shift, op4, ui5, rj, rd};
  endfunction

  function automatic logic [31:0] lu12i_inst(input logic [19:0] si20, input logic [4:0] rd);
    return {id_pkg::op_lu12i, 1'b0, si20, rd};
  endfunction

  // low half of the offset sits in the upper field
  function automatic logic [31:0] offs26_inst(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
  endfunction

  function automatic logic [31:0] offs16_inst(input logic [5:0] op, input logic [15:0] offs,
                                              input logic [4:0] rj, input logic [4:0] rd);
    return {op, offs, rj, rd};
  endfunction

  task automatic compare(input string test, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error: %s %s expected %h actual %h", test, field, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_entry(input string name, input logic [31:0] i0, input logic [31:0] i1,
                           input logic [1:0] valid, input logic ready, input logic flush_in,
                           input logic [1:0] pop_exp, input logic [1:0] ev,
                           input logic [11:0] alu, input logic [4:0] dest,
                           input logic [31:0] imm, input logic [31:0] rj,
                           input logic [31:0] rkd, input logic [4:0] dest1,
                           input logic [31:0] rj1, input logic [31:0] rkd1);
    table_q.push_back({i0, i1, valid, ready, flush_in, pop_exp, ev, alu, dest, imm, rj, rkd,
                       dest1, rj1, rkd1});
    name_q.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] spare;
    logic [31:0] held;
    // independent slot 1 filler, or r20, r21, r22
    spare = reg3_inst(id_pkg::op4_or, 22, 21, 20);
    held  = reg3_inst(id_pkg::op4_sub, 11, 10, 9);
    add_entry("add", reg3_inst(id_pkg::op4_add, 2, 1, 3), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h001, 3, 0, reg_value(1), reg_value(2),
              20, reg_value(21), reg_value(22));
    add_entry("sub", reg3_inst(id_pkg::op4_sub, 9, 8, 7), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h002, 7, 0, reg_value(8), reg_value(9),
              20, reg_value(21), reg_value(22));
    add_entry("sltu", reg3_inst(id_pkg::op4_sltu, 6, 5, 4), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h008, 4, 0, reg_value(5), reg_value(6),
              20, reg_value(21), reg_value(22));
    add_entry("nor", reg3_inst(id_pkg::op4_nor, 12, 11, 10), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h020, 10, 0, reg_value(11), reg_value(12),
              20, reg_value(21), reg_value(22));
    add_entry("sra", reg3_inst(id_pkg::op4_sra, 15, 14, 13), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h400, 13, 0, reg_value(14), reg_value(15),
              20, reg_value(21), reg_value(22));
    // rk field overlaps the immediate
    add_entry("addi", imm12_inst(id_pkg::op_alu, id_pkg::op2_addi, 12'hff0, 2, 5), spare,
              2'b11, 1, 0, 2'b11, 2'b11, 12'h001, 5, 32'hfffffff0, reg_value(2), reg_value(16),
              20, reg_value(21), reg_value(22));
    add_entry("andi", imm12_inst(id_pkg::op_alu, id_pkg::op2_andi, 12'hfff, 3, 6), spare,
              2'b11, 1, 0, 2'b11, 2'b11, 12'h010, 6, 32'h00000fff, reg_value(3), reg_value(31),
              20, reg_value(21), reg_value(22));
    add_entry("slli", shifti_inst(id_pkg::op4_slli, 7, 9, 8), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h100, 8, 32'd7, reg_value(9), reg_value(7),
              20, reg_value(21), reg_value(22));
    add_entry("lu12i", lu12i_inst(20'h80001, 12), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h800, 12, 32'h80001000, reg_value(1), reg_value(0),
              20, reg_value(21), reg_value(22));
    add_entry("st_w", imm12_inst(id_pkg::op_mem, id_pkg::op2_st_w, 12'h004, 2, 9), spare,
              2'b11, 1, 0, 2'b11, 2'b11, 12'h001, 9, 32'd4, reg_value(2), reg_value(9),
              20, reg_value(21), reg_value(22));
    add_entry("bl", offs26_inst(id_pkg::op_bl, 26'h3fffffc), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h001, 1, 32'hfffffffc, reg_value(31), reg_value(28),
              20, reg_value(21), reg_value(22));
    add_entry("raw_rj", reg3_inst(id_pkg::op4_add, 2, 1, 5), reg3_inst(id_pkg::op4_add, 3, 5, 6),
              2'b11, 1, 0, 2'b01, 2'b01, 12'h001, 5, 0, reg_value(1), reg_value(2),
              0, 0, 0);
    add_entry("raw_rk", imm12_inst(id_pkg::op_alu, id_pkg::op2_ori, 12'h0f0, 4, 7),
              reg3_inst(id_pkg::op4_xor, 7, 8, 9), 2'b11, 1, 0,
              2'b01, 2'b01, 12'h040, 7, 32'h000000f0, reg_value(4), reg_value(16),
              0, 0, 0);
    add_entry("ld_st", imm12_inst(id_pkg::op_mem, id_pkg::op2_ld_w, 12'h008, 2, 4),
              imm12_inst(id_pkg::op_mem, id_pkg::op2_st_b, 12'h000, 3, 9), 2'b11, 1, 0,
              2'b01, 2'b01, 12'h001, 4, 32'd8, reg_value(2), reg_value(8),
              0, 0, 0);
    add_entry("ld_jirl", imm12_inst(id_pkg::op_mem, id_pkg::op2_ld_b, 12'h000, 2, 4),
              offs16_inst(id_pkg::op_jirl, 16'h0000, 10, 1), 2'b11, 1, 0,
              2'b01, 2'b01, 12'h001, 4, 0, reg_value(2), reg_value(0),
              0, 0, 0);
    add_entry("ld_bl", imm12_inst(id_pkg::op_mem, id_pkg::op2_ld_h, 12'h002, 2, 4),
              offs26_inst(id_pkg::op_bl, 26'h10), 2'b11, 1, 0,
              2'b01, 2'b01, 12'h001, 4, 32'd2, reg_value(2), reg_value(2),
              0, 0, 0);
    add_entry("r0_write", reg3_inst(id_pkg::op4_add, 2, 1, 0), reg3_inst(id_pkg::op4_add, 0, 0, 3),
              2'b11, 1, 0, 2'b11, 2'b11, 12'h001, 0, 0, reg_value(1), reg_value(2),
              3, reg_value(0), reg_value(0));
    add_entry("stall_fill", reg3_inst(id_pkg::op4_xor, 4, 3, 2), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h080, 2, 0, reg_value(3), reg_value(4),
              20, reg_value(21), reg_value(22));
    // outputs keep the xor pair while execute stalls
    for (int s = 0; s < 3; s++)
      add_entry("stall_hold", held, spare, 2'b11, 0, 0,
                2'b00, 2'b11, 12'h080, 2, 0, reg_value(3), reg_value(4),
                20, reg_value(21), reg_value(22));
    add_entry("release", held, spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h002, 9, 0, reg_value(10), reg_value(11),
              20, reg_value(21), reg_value(22));
    add_entry("flush", reg3_inst(id_pkg::op4_add, 2, 1, 3), spare, 2'b11, 1, 1,
              2'b11, 2'b00, 12'h000, 0, 0, 0, 0, 0, 0, 0);
    add_entry("after_flush", reg3_inst(id_pkg::op4_add, 2, 1, 3), spare, 2'b11, 1, 0,
              2'b11, 2'b11, 12'h001, 3, 0, reg_value(1), reg_value(2),
              20, reg_value(21), reg_value(22));
    add_entry("idle", spare, spare, 2'b00, 1, 0, 2'b00, 2'b00, 12'h000, 0, 0, 0, 0,
              0, 0, 0);
    add_entry("slot1_only", spare, spare, 2'b10, 1, 0, 2'b00, 2'b00, 12'h000, 0, 0, 0, 0,
              0, 0, 0);
  endtask

  initial
  begin
    for (int c = 0; c < watchdog_cycles; c++)
      @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("*** FAILED ***");
    $fatal(1, "timeout");
  end

  initial
  begin
    build_table();
    // valid traffic during reset must not reach execute
    rst_n       = 1'b0;
    inst0       = reg3_inst(id_pkg::op4_add, 2, 1, 3);
    inst1       = reg3_inst(id_pkg::op4_or, 22, 21, 20);
    pc0         = 32'h1c000000;
    pc1         = 32'h1c000004;
    inst0_valid = 1'b1;
    inst1_valid = 1'b1;
    exe_ready   = 1'b1;
    flush       = 1'b0;
    for (int c = 0; c < 7; c++)
      @(posedge clk);
    @(negedge clk);
    compare("reset", "exe_valid0", 0, 32'(exe_valid0));
    compare("reset", "exe_valid1", 0, 32'(exe_valid1));
    @(posedge clk);
    rst_n <= 1'b1;

    for (int n = 0; n < table_q.size(); n++)
    begin
      e = table_q[n];
      @(posedge clk);
      inst0       <= e.i0;
      inst1       <= e.i1;
      pc0         <= 32'h1c000000 + 32'(n) * 32'd8;
      pc1         <= 32'h1c000004 + 32'(n) * 32'd8;
      inst0_valid <= e.valid[0];
      inst1_valid <= e.valid[1];
      exe_ready   <= e.ready;
      flush       <= e.flush;
      @(negedge clk);
      compare(name_q[n], "pop", 32'(e.pop), 32'(pop));
      @(posedge clk);
      @(negedge clk);
      compare(name_q[n], "exe_valid0", 32'(e.ev[0]), 32'(exe_valid0));
      compare(name_q[n], "exe_valid1", 32'(e.ev[1]), 32'(exe_valid1));
      if (e.ev[0])
      begin
        compare(name_q[n], "alu_op", 32'(e.alu), 32'(exe_bundle0.alu_op));
        compare(name_q[n], "dest", 32'(e.dest), 32'(exe_bundle0.dest));
        compare(name_q[n], "imm", e.imm, exe_bundle0.imm);
        compare(name_q[n], "rj_value", e.rj, exe_bundle0.rj_value);
        compare(name_q[n], "rkd_value", e.rkd, exe_bundle0.rkd_value);
      end
      if (e.ev[1])
      begin
        compare(name_q[n], "dest1", 32'(e.dest1), 32'(exe_bundle1.dest));
        compare(name_q[n], "rj_value1", e.rj1, exe_bundle1.rj_value);
        compare(name_q[n], "rkd_value1", e.rkd1, exe_bundle1.rkd_value);
      end
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* sim.f */
source/id_pkg.sv
source/inst_decoder.sv
source/pair_check.sv
source/issue_reg.sv
source/id_stage.sv
bench/id_stage_tb.sv

/* Makefile */
# Verilator build and run for the decode and issue stage

VERILATOR  ?= verilator
TOP        ?= id_stage_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
